// File: lsu_lite.f
+incdir+include
hdl/lsu_pkg.sv
hdl/lsu_issue_select.sv
hdl/lsu_replay_queue.sv
hdl/lsu_exec_stage.sv
hdl/lsu_result_stage.sv
hdl/lsu_top.sv
verif/lsu_sva.sv
verif/lsu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the load/store unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lsu_tb \
  -f lsu_lite.f -o lsu_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Build failed with status $status"
  exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" sim.log; then
  exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// File: verif/lsu_tb.sv
// Testbench for lsu_top: directed and random load/store traffic checked
// against a program-order memory model by immediate assertions.

`timescale 1ns/1ns

`include "lsu_params.svh"

module lsu_tb;

  import lsu_pkg::*;

  localparam int MEM_WORDS = 1 << `LSU_ADDR_W;
  localparam int TAGS      = 1 << `LSU_TAG_W;

  logic      i_clk;
  logic      i_rst;
  logic      i_req_valid;
  lsu_req_t  i_req;
  logic      i_rsp_ready;
  logic      o_req_ready;
  logic      o_rsp_valid;
  lsu_rsp_t  o_rsp;

  // Program-order memory and one expectation per tag
  logic [`LSU_DATA_W-1:0]  model_mem [MEM_WORDS];
  logic [`LSU_DATA_W-1:0]  exp_data  [TAGS];
  lsu_op_e                 exp_op    [TAGS];
  logic                    pending   [TAGS];
  logic [`LSU_TAG_W-1:0]   next_tag;
  int                      n_pending;

  lsu_req_t     send_q [$];
  logic         req_taken;
  int           ready_mode;
  logic [31:0]  lcg_state;
  int           value_errs;
  int           other_errs;
  int           n_rsp;

  lsu_top i_lsu_top (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .i_rsp_ready (i_rsp_ready),
    .o_req_ready (o_req_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp       (o_rsp)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic queue_req(input lsu_op_e op, input logic [`LSU_ADDR_W-1:0] addr,
                           input logic [`LSU_DATA_W-1:0] data);
    lsu_req_t r;
    r.op    = op;
    r.addr  = addr;
    r.wdata = data;
    send_q.push_back(r);
  endtask

  // ------------------------------------------------------------------------
  // Model update at acceptance, response checks
  // ------------------------------------------------------------------------

  task automatic record_req(input lsu_req_t r);
    assert (!pending[next_tag]) else begin
      other_errs++;
      $display("Tag %0d handed out again while its response is still due", next_tag);
    end
    exp_op[next_tag] = r.op;
    if (r.op == LSU_OP_STORE) begin
      model_mem[r.addr]  = r.wdata;
      exp_data[next_tag] = '0;
    end else begin
      exp_data[next_tag] = model_mem[r.addr];
    end
    pending[next_tag] = 1'b1;
    n_pending++;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic check_rsp(input lsu_rsp_t r);
    assert (pending[r.tag]) else begin
      other_errs++;
      $display("Response with tag %0d arrived while none was due", r.tag);
    end
    if (pending[r.tag]) begin
      assert (r.op == exp_op[r.tag]) else begin
        value_errs++;
        $display("** Error o_rsp.op tag %0h: expected %0h, got %0h",
                 r.tag, exp_op[r.tag], r.op);
      end
      if (r.op == LSU_OP_LOAD) begin
        assert (r.rdata == exp_data[r.tag]) else begin
          value_errs++;
          $display("** Error o_rsp.rdata tag %0h: expected %08h, got %08h",
                   r.tag, exp_data[r.tag], r.rdata);
        end
      end
      pending[r.tag] = 1'b0;
      n_pending--;
      n_rsp++;
    end
  endtask

  // One clock: drive on the falling edge, then note the transfers that
  // the next rising edge will make
  task automatic run_cycle();
    logic [31:0] r;
    @(negedge i_clk);
    if (req_taken) begin
      i_req_valid = 1'b0;
      req_taken   = 1'b0;
    end
    if (!i_req_valid && send_q.size() != 0) begin
      i_req       = send_q.pop_front();
      i_req_valid = 1'b1;
    end
    case (ready_mode)
      0: i_rsp_ready = 1'b1;
      1: begin
        r = next_rand();
        i_rsp_ready = (r[29:28] != 2'b00);
      end
      default: i_rsp_ready = 1'b0;
    endcase
    if (i_req_valid && o_req_ready) begin
      record_req(i_req);
      req_taken = 1'b1;
    end
    if (o_rsp_valid && i_rsp_ready) begin
      check_rsp(o_rsp);
    end
  endtask

  task automatic drain(input int limit);
    int n;
    n = 0;
    while ((send_q.size() != 0 || i_req_valid || n_pending != 0) && n < limit) begin
      run_cycle();
      n++;
    end
    assert (send_q.size() == 0 && !i_req_valid && n_pending == 0) else begin
      other_errs++;
      $display("Timeout: %0d responses still due after %0d cycles", n_pending, limit);
    end
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------

  initial begin
    lsu_rsp_t     held;
    int           n;
    logic [31:0]  r;
    i_rst       = 1'b1;
    i_req_valid = 1'b0;
    i_req       = '0;
    i_rsp_ready = 1'b0;
    req_taken   = 1'b0;
    ready_mode  = 0;
    lcg_state   = 32'hdfcd;
    next_tag    = '0;
    n_pending   = 0;
    value_errs  = 0;
    other_errs  = 0;
    n_rsp       = 0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      model_mem[a] = '0;
    end
    for (int t = 0; t < TAGS; t++) begin
      pending[t]  = 1'b0;
      exp_data[t] = '0;
      exp_op[t]   = LSU_OP_LOAD;
    end
    repeat (4) @(negedge i_clk);
    i_rst = 1'b0;

    // Idle state after reset, memory reads back zero
    assert (!o_rsp_valid) else begin
      value_errs++;
      $display("** Error o_rsp_valid after reset: expected 0, got %0h", o_rsp_valid);
    end
    assert (o_req_ready) else begin
      value_errs++;
      $display("** Error o_req_ready after reset: expected 1, got %0h", o_req_ready);
    end
    queue_req(LSU_OP_LOAD, 4'd0, '0);
    queue_req(LSU_OP_LOAD, 4'd5, '0);
    queue_req(LSU_OP_LOAD, 4'd15, '0);
    drain(200);

    // Store then load, same address
    queue_req(LSU_OP_STORE, 4'd3, 32'h1234_5678);
    queue_req(LSU_OP_LOAD, 4'd3, '0);
    queue_req(LSU_OP_STORE, 4'd9, 32'h0bad_f00d);
    queue_req(LSU_OP_LOAD, 4'd9, '0);
    drain(200);

    // Load right behind a store to the same bank replays
    queue_req(LSU_OP_STORE, 4'd6, 32'ha5a5_0006);
    queue_req(LSU_OP_LOAD, 4'd2, '0);
    queue_req(LSU_OP_STORE, 4'd7, 32'h5a5a_0007);
    queue_req(LSU_OP_LOAD, 4'd11, '0);
    queue_req(LSU_OP_LOAD, 4'd6, '0);
    drain(200);

    // Responses held back until the request port closes
    ready_mode = 2;
    for (int i = 0; i < 10; i++) begin
      queue_req(i[0] ? LSU_OP_LOAD : LSU_OP_STORE, 4'(i & ~1), 32'h100 + i);
    end
    n = 0;
    while (o_req_ready && n < 50) begin
      run_cycle();
      n++;
    end
    assert (!o_req_ready && o_rsp_valid) else begin
      other_errs++;
      $display("Timeout: request port never closed with a response held");
    end
    held = o_rsp;
    repeat (5) begin
      run_cycle();
      assert (o_rsp == held) else begin
        value_errs++;
        $display("** Error o_rsp while stalled: expected %010h, got %010h", held, o_rsp);
      end
    end
    ready_mode = 0;
    drain(400);

    // Random mix with random back-pressure, tags wrap many times
    ready_mode = 1;
    for (int i = 0; i < 300; i++) begin
      r = next_rand();
      queue_req(r[20] ? LSU_OP_STORE : LSU_OP_LOAD, r[27:24], next_rand());
    end
    drain(20000);

    $display("Error counts: %0d wrong values, %0d other failures, %0d responses checked",
             value_errs, other_errs, n_rsp);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: verif/lsu_sva.sv
// Protocol checks on the request and response ports of the load/store unit.
// Bound to lsu_top so every simulation of the top level carries them.

`timescale 1ns/1ns

module lsu_sva (
  input logic               i_clk,
  input logic               i_rst,
  input logic               i_req_valid,
  input lsu_pkg::lsu_req_t  i_req,
  input logic               i_req_ready,
  input logic               i_rsp_valid,
  input lsu_pkg::lsu_rsp_t  i_rsp,
  input logic               i_rsp_ready
);

  // Held response keeps valid and payload
  a_rsp_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_rsp_valid && !i_rsp_ready) |=> (i_rsp_valid && $stable(i_rsp)))
    else $error("o_rsp changed while the response was stalled");

  // Nothing comes out right after reset
  a_rsp_reset: assert property (@(posedge i_clk) i_rst |=> !i_rsp_valid)
    else $error("o_rsp_valid high in the cycle after reset");

  // Request waits with a stable payload until taken
  a_req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_req_valid && !i_req_ready) |=> (i_req_valid && $stable(i_req)))
    else $error("i_req dropped or changed before it was accepted");

endmodule

bind lsu_top lsu_sva u_lsu_sva (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_req_valid (i_req_valid),
  .i_req       (i_req),
  .i_req_ready (o_req_ready),
  .i_rsp_valid (o_rsp_valid),
  .i_rsp       (o_rsp),
  .i_rsp_ready (i_rsp_ready)
);

// File: hdl/lsu_top.sv
// Top level of the load/store unit: issue select, replay queue, execute and
// result stages wired together. Requests in and responses out are valid/ready.

`timescale 1ns/1ns

`include "lsu_params.svh"

module lsu_top (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_req_valid,
  input  lsu_pkg::lsu_req_t   i_req,
  input  logic                i_rsp_ready,
  output logic                o_req_ready,
  output logic                o_rsp_valid,
  output lsu_pkg::lsu_rsp_t   o_rsp
);

  import lsu_pkg::*;

  lsu_issue_t                                w_issue;
  lsu_issue_t                                w_rq_head;
  logic [$clog2(`LSU_RQ_DEPTH+1)-1:0]        w_rq_free;
  logic                                      w_rq_pop;
  logic                                      w_replay;
  lsu_issue_t                                w_replay_op;
  logic                                      w_done;
  lsu_rsp_t                                  w_done_rsp;
  logic                                      w_stall;
  logic                                      w_ld_inflight_ex;
  logic                                      w_ld_inflight_rs;

  // --------------------------------------------------------------------------
  // Issue side
  // --------------------------------------------------------------------------

  lsu_issue_select u_issue_select (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_req_valid      (i_req_valid),
    .i_req            (i_req),
    .i_rq_head        (w_rq_head),
    .i_rq_free        (w_rq_free),
    .i_stall          (w_stall),
    .i_ld_inflight_ex (w_ld_inflight_ex),
    .i_ld_inflight_rs (w_ld_inflight_rs),
    .o_req_ready      (o_req_ready),
    .o_rq_pop         (w_rq_pop),
    .o_issue          (w_issue)
  );

  lsu_replay_queue u_replay_queue (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_push    (w_replay),
    .i_push_op (w_replay_op),
    .i_pop     (w_rq_pop),
    .o_head    (w_rq_head),
    .o_free    (w_rq_free)
  );

  // --------------------------------------------------------------------------
  // Execute and result
  // --------------------------------------------------------------------------

  lsu_exec_stage u_exec_stage (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_op          (w_issue),
    .i_stall       (w_stall),
    .o_replay      (w_replay),
    .o_replay_op   (w_replay_op),
    .o_done        (w_done),
    .o_done_rsp    (w_done_rsp),
    .o_ld_inflight (w_ld_inflight_ex)
  );

  lsu_result_stage u_result_stage (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_done        (w_done),
    .i_done_rsp    (w_done_rsp),
    .i_rsp_ready   (i_rsp_ready),
    .o_rsp_valid   (o_rsp_valid),
    .o_rsp         (o_rsp),
    .o_stall       (w_stall),
    .o_ld_inflight (w_ld_inflight_rs)
  );

endmodule

// File: hdl/lsu_result_stage.sv
// Response register of the load/store unit with valid/ready back-pressure.
// A held response stalls every earlier stage.

`timescale 1ns/1ns

module lsu_result_stage (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_done,
  input  lsu_pkg::lsu_rsp_t   i_done_rsp,
  input  logic                i_rsp_ready,
  output logic                o_rsp_valid,
  output lsu_pkg::lsu_rsp_t   o_rsp,
  output logic                o_stall,
  output logic                o_ld_inflight
);

  import lsu_pkg::*;

  // Response waiting and not taken this cycle
  assign o_stall = o_rsp_valid & ~i_rsp_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rsp_valid <= 1'b0;
    end else if (!o_stall) begin
      o_rsp_valid <= i_done;
    end
  end

  // Payload only loads on a new completion
  always_ff @(posedge i_clk) begin
    if (!o_stall && i_done) begin
      o_rsp <= i_done_rsp;
    end
  end

  assign o_ld_inflight = o_rsp_valid & (o_rsp.op == LSU_OP_LOAD);

endmodule

// File: hdl/lsu_exec_stage.sv
// Execute stage: four-bank data memory with per-bank busy tracking.
// Loads to a bank written in the previous cycle go back for replay.

`timescale 1ns/1ns

`include "lsu_params.svh"

module lsu_exec_stage (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  lsu_pkg::lsu_issue_t   i_op,
  input  logic                  i_stall,
  output logic                  o_replay,
  output lsu_pkg::lsu_issue_t   o_replay_op,
  output logic                  o_done,
  output lsu_pkg::lsu_rsp_t     o_done_rsp,
  output logic                  o_ld_inflight
);

  import lsu_pkg::*;

  localparam int BANK_W = $clog2(`LSU_BANKS);
  localparam int IDX_W  = `LSU_ADDR_W - BANK_W;
  localparam int WORDS  = (1 << `LSU_ADDR_W) / `LSU_BANKS;

  logic [`LSU_DATA_W-1:0]  bank_mem [`LSU_BANKS][WORDS];
  logic [`LSU_BANKS-1:0]   bank_busy_q;
  logic [`LSU_BANKS-1:0]   wr_bank_oh;
  logic [BANK_W-1:0]       bank;
  logic [IDX_W-1:0]        idx;
  logic                    is_load;
  logic                    st_fire;
  lsu_replay_e             cause;

  assign bank    = i_op.addr[BANK_W-1:0];
  assign idx     = i_op.addr[`LSU_ADDR_W-1:BANK_W];
  assign is_load = i_op.valid & (i_op.op == LSU_OP_LOAD);

  // --------------------------------------------------------------------------
  // Replay decision
  // --------------------------------------------------------------------------

  always_comb begin
    cause = LSU_RP_NONE;
    if (is_load && bank_busy_q[bank]) begin
      cause = LSU_RP_BANK_BUSY;
    end
  end

  assign o_replay    = is_load & (cause == LSU_RP_BANK_BUSY) & ~i_stall;
  assign o_replay_op = i_op;

  // Store holds off while the result register is stalled
  assign st_fire    = i_op.valid & (i_op.op == LSU_OP_STORE) & ~i_stall;
  assign wr_bank_oh = st_fire ? (`LSU_BANKS'(1) << bank) : '0;

  // --------------------------------------------------------------------------
  // Banked memory and busy bits
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int b = 0; b < `LSU_BANKS; b++) begin
        for (int w = 0; w < WORDS; w++) begin
          bank_mem[b][w] <= '0;
        end
      end
    end else if (st_fire) begin
      bank_mem[bank][idx] <= i_op.wdata;
    end
  end

  // Busy for one cycle after a write
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      bank_busy_q <= '0;
    end else if (!i_stall) begin
      bank_busy_q <= wr_bank_oh;
    end
  end

  // Completion, load data read straight from the bank
  assign o_done           = i_op.valid & (cause == LSU_RP_NONE) & ~i_stall;
  assign o_done_rsp.tag   = i_op.tag;
  assign o_done_rsp.op    = i_op.op;
  assign o_done_rsp.rdata = is_load ? bank_mem[bank][idx] : '0;

  assign o_ld_inflight = is_load;

endmodule

// File: hdl/lsu_replay_queue.sv
// FIFO of loads refused by the execute stage, waiting to be issued again.
// The free-entry count feeds the issue throttle in the select stage.

`timescale 1ns/1ns

`include "lsu_params.svh"

module lsu_replay_queue (
  input  logic                                  i_clk,
  input  logic                                  i_rst,
  input  logic                                  i_push,
  input  lsu_pkg::lsu_issue_t                   i_push_op,
  input  logic                                  i_pop,
  output lsu_pkg::lsu_issue_t                   o_head,
  output logic [$clog2(`LSU_RQ_DEPTH+1)-1:0]    o_free
);

  import lsu_pkg::*;

  localparam int RQ_PTR_W = $clog2(`LSU_RQ_DEPTH);
  localparam int RQ_CNT_W = $clog2(`LSU_RQ_DEPTH + 1);

  lsu_issue_t           rq_mem [`LSU_RQ_DEPTH];
  logic [RQ_PTR_W-1:0]  wr_ptr;
  logic [RQ_PTR_W-1:0]  rd_ptr;
  logic [RQ_CNT_W-1:0]  count;
  logic                 do_pop;

  // Pop only when something is there
  assign do_pop = i_pop & (count != '0);

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      rq_mem[wr_ptr] <= i_push_op;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == RQ_PTR_W'(`LSU_RQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == RQ_PTR_W'(`LSU_RQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (i_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (!i_push && do_pop) begin
        count <= count - 1'b1;
      end
    end
  end

  // Head entry, valid flag follows the occupancy
  always_comb begin
    o_head       = rq_mem[rd_ptr];
    o_head.valid = (count != '0);
  end

  assign o_free = RQ_CNT_W'(`LSU_RQ_DEPTH) - count;

endmodule

// File: hdl/lsu_issue_select.sv
// Issue side of the load/store unit: in-order request FIFO with tagging, and
// age-based choice between the FIFO head and the replay queue head.

`timescale 1ns/1ns

`include "lsu_params.svh"

module lsu_issue_select (
  input  logic                                  i_clk,
  input  logic                                  i_rst,
  input  logic                                  i_req_valid,
  input  lsu_pkg::lsu_req_t                     i_req,
  input  lsu_pkg::lsu_issue_t                   i_rq_head,
  input  logic [$clog2(`LSU_RQ_DEPTH+1)-1:0]    i_rq_free,
  input  logic                                  i_stall,
  input  logic                                  i_ld_inflight_ex,
  input  logic                                  i_ld_inflight_rs,
  output logic                                  o_req_ready,
  output logic                                  o_rq_pop,
  output lsu_pkg::lsu_issue_t                   o_issue
);

  import lsu_pkg::*;

  localparam int IQ_PTR_W = $clog2(`LSU_IQ_DEPTH);
  localparam int IQ_CNT_W = $clog2(`LSU_IQ_DEPTH + 1);

  lsu_issue_t             iq_mem [`LSU_IQ_DEPTH];
  logic [IQ_PTR_W-1:0]    iq_wr_ptr;
  logic [IQ_PTR_W-1:0]    iq_rd_ptr;
  logic [IQ_CNT_W-1:0]    iq_count;
  logic [`LSU_TAG_W-1:0]  tag_q;

  lsu_issue_t             iq_wr_entry;
  lsu_issue_t             iq_head;
  lsu_issue_t             sel_op;
  logic                   iq_push;
  logic                   iq_pop;
  logic                   iq_stop;
  logic                   ld_pending;
  logic                   iq_ok;
  logic                   pick_rq;

  // --------------------------------------------------------------------------
  // Request FIFO with sequence tags
  // --------------------------------------------------------------------------

  assign o_req_ready = (iq_count != IQ_CNT_W'(`LSU_IQ_DEPTH));
  assign iq_push     = i_req_valid & o_req_ready;

  always_comb begin
    iq_wr_entry.valid = 1'b1;
    iq_wr_entry.op    = i_req.op;
    iq_wr_entry.tag   = tag_q;
    iq_wr_entry.addr  = i_req.addr;
    iq_wr_entry.wdata = i_req.wdata;
  end

  always_ff @(posedge i_clk) begin
    if (iq_push) begin
      iq_mem[iq_wr_ptr] <= iq_wr_entry;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      iq_wr_ptr <= '0;
      iq_rd_ptr <= '0;
      iq_count  <= '0;
      tag_q     <= '0;
    end else begin
      if (iq_push) begin
        iq_wr_ptr <= (iq_wr_ptr == IQ_PTR_W'(`LSU_IQ_DEPTH - 1)) ? '0 : iq_wr_ptr + 1'b1;
        tag_q     <= tag_q + 1'b1;
      end
      if (iq_pop) begin
        iq_rd_ptr <= (iq_rd_ptr == IQ_PTR_W'(`LSU_IQ_DEPTH - 1)) ? '0 : iq_rd_ptr + 1'b1;
      end
      if (iq_push && !iq_pop) begin
        iq_count <= iq_count + 1'b1;
      end else if (!iq_push && iq_pop) begin
        iq_count <= iq_count - 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Select between issue head and replay head
  // --------------------------------------------------------------------------

  always_comb begin
    iq_head       = iq_mem[iq_rd_ptr];
    iq_head.valid = (iq_count != '0);
  end

  // Replay queue nearly full, hold new work back
  assign iq_stop    = (i_rq_free <= 1);
  // Loads still able to read memory after a store would write it
  assign ld_pending = i_ld_inflight_ex | i_ld_inflight_rs | i_rq_head.valid;

  assign iq_ok   = iq_head.valid & ~iq_stop &
                   ~((iq_head.op == LSU_OP_STORE) & ld_pending);
  assign pick_rq = i_rq_head.valid &
                   (~iq_ok | lsu_tag_older(i_rq_head.tag, iq_head.tag));

  assign o_rq_pop = pick_rq & ~i_stall;
  assign iq_pop   = ~pick_rq & iq_ok & ~i_stall;

  always_comb begin
    if (pick_rq) begin
      sel_op = i_rq_head;
    end else begin
      sel_op       = iq_head;
      sel_op.valid = iq_ok;
    end
  end

  // Issue register, held while the response port is stalled
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_issue.valid <= 1'b0;
    end else if (!i_stall) begin
      o_issue <= sel_op;
    end
  end

endmodule

// File: hdl/lsu_pkg.sv
// Types shared by the load/store unit stages: opcodes, replay causes, payloads.
// Modules take the types by scoped name in ports and by import in the body.

`include "lsu_params.svh"

package lsu_pkg;

  // --------------------------------------------------------------------------
  // Enumerations
  // --------------------------------------------------------------------------

  typedef enum logic {
    LSU_OP_LOAD  = 1'b0,
    LSU_OP_STORE = 1'b1
  } lsu_op_e;

  // Why an operation was sent back to the replay queue
  typedef enum logic {
    LSU_RP_NONE      = 1'b0,
    LSU_RP_BANK_BUSY = 1'b1
  } lsu_replay_e;

  // --------------------------------------------------------------------------
  // Payloads
  // --------------------------------------------------------------------------

  // External request, 37 bits
  typedef struct packed {
    lsu_op_e                 op;
    logic [`LSU_ADDR_W-1:0]  addr;
    logic [`LSU_DATA_W-1:0]  wdata;
  } lsu_req_t;

  // Operation moving between stages, 43 bits
  typedef struct packed {
    logic                    valid;
    lsu_op_e                 op;
    logic [`LSU_TAG_W-1:0]   tag;
    logic [`LSU_ADDR_W-1:0]  addr;
    logic [`LSU_DATA_W-1:0]  wdata;
  } lsu_issue_t;

  // Response, 38 bits
  typedef struct packed {
    logic [`LSU_TAG_W-1:0]   tag;
    lsu_op_e                 op;
    logic [`LSU_DATA_W-1:0]  rdata;
  } lsu_rsp_t;

  // Tag a is older than tag b when a - b wraps negative
  function automatic logic lsu_tag_older(input logic [`LSU_TAG_W-1:0] a,
                                         input logic [`LSU_TAG_W-1:0] b);
    logic [`LSU_TAG_W-1:0] diff;
    diff = a - b;
    return diff[`LSU_TAG_W-1];
  endfunction

endpackage

// File: include/lsu_params.svh
// Size settings for the load/store unit, shared by the package and all RTL.
// Include this file wherever a width or a depth is needed.

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Sequence tag width, wraps at 32
`define LSU_TAG_W     5

// Word address, low bits select the bank
`define LSU_ADDR_W    4
`define LSU_DATA_W    32

// Queue depths
`define LSU_IQ_DEPTH  4
`define LSU_RQ_DEPTH  4

// Data memory banking
`define LSU_BANKS     4

`endif
